// ==== verilog/lsu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types for the load/store unit. Ids are 3 bits, data is 32 bits
//////////////////////////////////////////////////////////////////////

`default_nettype none

package lsu_pkg;

    //////////////////////////////////////////////////////////////////
    // Scalar types
    typedef logic [2:0] ls_id_t;
    typedef logic [2:0] ls_fn3_t;

    // RISC-V load/store funct3 encodings
    localparam ls_fn3_t LS_B_FN3 = 3'b000;
    localparam ls_fn3_t LS_H_FN3 = 3'b001;
    localparam ls_fn3_t LS_W_FN3 = 3'b010;
    localparam ls_fn3_t L_BU_FN3 = 3'b100;
    localparam ls_fn3_t L_HU_FN3 = 3'b101;

    //////////////////////////////////////////////////////////////////
    // One data word, viewed as byte lanes or as halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } ls_word_u;

    // Request as presented by the core
    typedef struct packed {
        ls_id_t      id;
        logic        load;
        logic        store;
        ls_fn3_t     fn3;
        logic [31:0] addr;
        logic [31:0] wdata;
    } ls_request_t;

    // Decoded request handed to the scratch memory
    typedef struct packed {
        ls_id_t      id;
        logic        load;
        logic        store;
        ls_fn3_t     fn3;
        logic [1:0]  byte_addr;
        logic [29:0] word_index;
        logic [3:0]  be;
        ls_word_u    wdata;
        logic        misaligned;
    } ls_issue_t;

    // One result per request, data is zero for stores and misaligned accesses
    typedef struct packed {
        ls_id_t      id;
        logic [31:0] data;
        logic        is_load;
        logic        misaligned;
    } ls_result_t;

endpackage

`default_nettype wire

// ==== verilog/ls_request_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Sender must hold a credit for every req_valid cycle; no full check
// One entry is popped per cycle while the queue is not empty
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ls_request_decode #(
    parameter int INPUT_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  lsu_pkg::ls_request_t req,
    output logic                 credit_return,
    output logic                 issue_valid,
    output lsu_pkg::ls_issue_t   issue
);

    localparam int PTR_W = (INPUT_DEPTH > 1) ? $clog2(INPUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(INPUT_DEPTH + 1);

    lsu_pkg::ls_request_t queue [INPUT_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic                 pop;
    lsu_pkg::ls_request_t head;
    lsu_pkg::ls_word_u    src_data;
    lsu_pkg::ls_word_u    lane_data;
    logic [3:0]           be;
    logic                 misaligned;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(INPUT_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////
    // Input queue
    always_ff @(posedge clk) begin
        if (req_valid) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(req_valid) - CNT_W'(pop);
        end
    end

    // Execute never stalls, so any head entry leaves right away
    assign pop           = (count != '0);
    assign credit_return = pop;
    assign issue_valid   = pop;
    assign head          = queue[rd_ptr];

    //////////////////////////////////////////////////////////////////
    // Alignment, byte enables and store lanes
    always_comb begin
        case (head.fn3[1:0])
            lsu_pkg::LS_H_FN3[1:0]: misaligned = head.addr[0];
            lsu_pkg::LS_W_FN3[1:0]: misaligned = |head.addr[1:0];
            default:                misaligned = 1'b0;
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (head.fn3[1:0])
                lsu_pkg::LS_B_FN3[1:0]: be[i] = (head.addr[1:0] == 2'(i));
                lsu_pkg::LS_H_FN3[1:0]: be[i] = (head.addr[1] == i[1]);
                default:                be[i] = 1'b1;
            endcase
            be[i] = be[i] & head.store;
        end
    end

    // Byte fills every lane, half fills both halves
    always_comb begin
        src_data  = head.wdata;
        lane_data = src_data;
        case (head.fn3[1:0])
            lsu_pkg::LS_B_FN3[1:0]: begin
                for (int i = 0; i < 4; i++) begin
                    lane_data.bytes[i] = src_data.bytes[0];
                end
            end
            lsu_pkg::LS_H_FN3[1:0]: begin
                lane_data.halves[1] = src_data.halves[0];
            end
            default: lane_data = src_data;
        endcase
    end

    always_comb begin
        issue.id         = head.id;
        issue.load       = head.load;
        issue.store      = head.store;
        issue.fn3        = head.fn3;
        issue.byte_addr  = head.addr[1:0];
        issue.word_index = head.addr[31:2];
        issue.be         = be;
        issue.wdata      = lane_data;
        issue.misaligned = misaligned;
    end

endmodule

`default_nettype wire

// ==== verilog/ls_scratch_memory.sv ====
//////////////////////////////////////////////////////////////////////
// Word index wraps modulo MEM_WORDS; reads return the pre-write word
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ls_scratch_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  lsu_pkg::ls_issue_t issue,
    output logic               mem_valid,
    output lsu_pkg::ls_word_u  mem_data,
    output lsu_pkg::ls_issue_t mem_attr
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    lsu_pkg::ls_word_u mem [MEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              write_en;

    assign idx      = IDX_W'(issue.word_index % 30'(MEM_WORDS));
    assign write_en = issue_valid & issue.store & ~issue.misaligned;

    //////////////////////////////////////////////////////////////////
    // Byte-enabled write, enables are already zero for loads
    always_ff @(posedge clk) begin
        if (write_en) begin
            for (int i = 0; i < 4; i++) begin
                if (issue.be[i]) begin
                    mem[idx].bytes[i] <= issue.wdata.bytes[i];
                end
            end
        end
    end

    // Registered read with the attributes riding along
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            mem_data <= mem[idx];
            mem_attr <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else begin
            mem_valid <= issue_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ls_load_result.sv ====
//////////////////////////////////////////////////////////////////////
// Result is a one-cycle pulse; the core cannot apply back-pressure
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ls_load_result (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_valid,
    input  lsu_pkg::ls_word_u  mem_data,
    input  lsu_pkg::ls_issue_t mem_attr,
    output logic               result_valid,
    output lsu_pkg::ls_result_t result
);

    lsu_pkg::ls_word_u half_sel;
    logic [7:0]        byte_val;
    logic [15:0]       half_val;
    logic [31:0]       load_data;

    //////////////////////////////////////////////////////////////////
    // Lane select, half first then byte within it
    always_comb begin
        half_sel           = mem_data;
        half_sel.halves[0] = mem_data.halves[mem_attr.byte_addr[1]];
        half_val           = half_sel.halves[0];
        byte_val           = half_sel.bytes[mem_attr.byte_addr[0]];
    end

    // Extension by funct3
    always_comb begin
        case (mem_attr.fn3)
            lsu_pkg::LS_B_FN3: load_data = {{24{byte_val[7]}}, byte_val};
            lsu_pkg::LS_H_FN3: load_data = {{16{half_val[15]}}, half_val};
            lsu_pkg::LS_W_FN3: load_data = mem_data;
            lsu_pkg::L_BU_FN3: load_data = {24'b0, byte_val};
            lsu_pkg::L_HU_FN3: load_data = {16'b0, half_val};
            // Reserved codes fall back to the raw word
            default:           load_data = mem_data;
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (mem_valid) begin
            result.id         <= mem_attr.id;
            result.is_load    <= mem_attr.load;
            result.misaligned <= mem_attr.misaligned;
            if (mem_attr.load && !mem_attr.misaligned) begin
                result.data <= load_data;
            end else begin
                result.data <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= mem_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/load_store_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Sender starts with INPUT_DEPTH credits; results come back in order
//////////////////////////////////////////////////////////////////////

`default_nettype none

module load_store_unit #(
    parameter int INPUT_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  lsu_pkg::ls_request_t req,
    output logic                 credit_return,
    output logic                 result_valid,
    output lsu_pkg::ls_result_t  result
);

    logic               issue_valid;
    lsu_pkg::ls_issue_t issue;
    logic               mem_valid;
    lsu_pkg::ls_word_u  mem_data;
    lsu_pkg::ls_issue_t mem_attr;

    // Queue, alignment check and lane setup
    ls_request_decode #(
        .INPUT_DEPTH(INPUT_DEPTH)
    ) decode_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .credit_return(credit_return),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

    ls_scratch_memory #(
        .MEM_WORDS(MEM_WORDS)
    ) memory_i (
        .clk        (clk),
        .rst        (rst),
        .issue_valid(issue_valid),
        .issue      (issue),
        .mem_valid  (mem_valid),
        .mem_data   (mem_data),
        .mem_attr   (mem_attr)
    );

    // Load alignment and result formatting
    ls_load_result result_i (
        .clk         (clk),
        .rst         (rst),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .mem_attr    (mem_attr),
        .result_valid(result_valid),
        .result      (result)
    );

endmodule

`default_nettype wire

// ==== test/lsu_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// Bound into load_store_unit; tracks credits from the port activity
//////////////////////////////////////////////////////////////////////

`default_nettype none

module lsu_assertions #(
    parameter int INPUT_DEPTH = 4
) (
    input logic                clk,
    input logic                rst,
    input logic                req_valid,
    input logic                credit_return,
    input logic                result_valid,
    input lsu_pkg::ls_result_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    // Entries sent and not yet popped
    int in_use;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_use <= 0;
        end else begin
            in_use <= in_use + int'(req_valid) - int'(credit_return);
        end
    end

    a_credit_limit: assert property (@(posedge clk) disable iff (rst)
        in_use <= INPUT_DEPTH)
        else $error("more credits in use than queue entries");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !result_valid && !credit_return)
        else $error("result or credit pulse right after reset");

    a_misaligned_zero: assert property (@(posedge clk) disable iff (rst)
        (result_valid && result.misaligned) |-> (result.data == '0))
        else $error("misaligned result carries nonzero data");

endmodule

bind load_store_unit lsu_assertions #(
    .INPUT_DEPTH(INPUT_DEPTH)
) assertions_i (
    .clk          (clk),
    .rst          (rst),
    .req_valid    (req_valid),
    .credit_return(credit_return),
    .result_valid (result_valid),
    .result       (result)
);

`default_nettype wire

// ==== test/lsu_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for load_store_unit. Only words 0 to 15 are used, all
// filled by stores before any load, since the scratch memory has no reset
//////////////////////////////////////////////////////////////////////

`default_nettype none

module lsu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int INPUT_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int LOAD_LATENCY = 3;

    // One stimulus row with its expected result
    typedef struct packed {
        logic             store;
        lsu_pkg::ls_fn3_t fn3;
        logic [31:0]      addr;
        logic [31:0]      wdata;
        logic             sync;
        logic [31:0]      exp_data;
        logic             exp_mis;
    } entry_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid;
    lsu_pkg::ls_request_t req;
    logic                 credit_return;
    logic                 result_valid;
    lsu_pkg::ls_result_t  result;

    entry_t      stim [$];
    int          sent_cycle [$];
    logic [31:0] ref_mem [16];
    logic [31:0] lfsr_state = 32'hfac9_1706;
    int          sent_count = 0;
    int          returned_count = 0;
    int          results_seen = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          pass_count = 0;
    int          err_count = 0;

    load_store_unit #(
        .INPUT_DEPTH(INPUT_DEPTH),
        .MEM_WORDS  (MEM_WORDS)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .credit_return(credit_return),
        .result_valid (result_valid),
        .result       (result)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////
    // Stimulus and reference model
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic misaligned_access(input lsu_pkg::ls_fn3_t fn3,
                                               input logic [31:0] addr);
        if (fn3[1:0] == 2'b01) begin
            return addr[0];
        end
        if (fn3[1:0] == 2'b10) begin
            return addr[1] | addr[0];
        end
        return 1'b0;
    endfunction

    // Applies one access to the model and queues it with its expected result
    task automatic add_access(input logic store, input lsu_pkg::ls_fn3_t fn3,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic sync);
        entry_t      e;
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        e.store    = store;
        e.fn3      = fn3;
        e.addr     = addr;
        e.wdata    = wdata;
        e.sync     = sync;
        e.exp_mis  = misaligned_access(fn3, addr);
        e.exp_data = '0;
        w = ref_mem[addr[5:2]];
        b = 8'(w >> {addr[1:0], 3'b000});
        h = 16'(w >> {addr[1], 4'b0000});
        if (!e.exp_mis && store) begin
            case (fn3)
                lsu_pkg::LS_B_FN3: w[{addr[1:0], 3'b000} +: 8] = wdata[7:0];
                lsu_pkg::LS_H_FN3: w[{addr[1], 4'b0000} +: 16] = wdata[15:0];
                default:           w = wdata;
            endcase
            ref_mem[addr[5:2]] = w;
        end else if (!e.exp_mis) begin
            case (fn3)
                lsu_pkg::LS_B_FN3: e.exp_data = {{24{b[7]}}, b};
                lsu_pkg::LS_H_FN3: e.exp_data = {{16{h[15]}}, h};
                lsu_pkg::L_BU_FN3: e.exp_data = {24'b0, b};
                lsu_pkg::L_HU_FN3: e.exp_data = {16'b0, h};
                default:           e.exp_data = w;
            endcase
        end
        stim.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] a;
        // Fill with LFSR data mixed with the address
        for (int w = 0; w < 16; w++) begin
            a = 32'(w * 4);
            add_access(1'b1, lsu_pkg::LS_W_FN3, a, rand_bits(32) ^ (a * 32'h9e37_79b9), 1'b0);
        end
        for (int w = 0; w < 16; w++) begin
            add_access(1'b0, lsu_pkg::LS_W_FN3, 32'(w * 4), '0, 1'b0);
        end
        // Byte lanes of word 6, half lanes of word 7
        for (int k = 0; k < 4; k++) begin
            add_access(1'b1, lsu_pkg::LS_B_FN3, 32'(24 + k), rand_bits(32), 1'b0);
            add_access(1'b0, lsu_pkg::LS_W_FN3, 32'd24, '0, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            add_access(1'b1, lsu_pkg::LS_H_FN3, 32'(28 + 2 * k), rand_bits(32), 1'b0);
            add_access(1'b0, lsu_pkg::LS_W_FN3, 32'd28, '0, 1'b0);
        end
        // Sign patterns in every byte and half
        add_access(1'b1, lsu_pkg::LS_W_FN3, 32'd32, 32'h807f_7f80, 1'b0);
        for (int k = 0; k < 4; k++) begin
            add_access(1'b0, lsu_pkg::LS_B_FN3, 32'(32 + k), '0, 1'b0);
            add_access(1'b0, lsu_pkg::L_BU_FN3, 32'(32 + k), '0, 1'b0);
        end
        for (int k = 0; k < 4; k += 2) begin
            add_access(1'b0, lsu_pkg::LS_H_FN3, 32'(32 + k), '0, 1'b0);
            add_access(1'b0, lsu_pkg::L_HU_FN3, 32'(32 + k), '0, 1'b0);
        end
        // Misaligned accesses, then readback of the untouched words
        add_access(1'b0, lsu_pkg::LS_H_FN3, 32'd33, '0, 1'b0);
        add_access(1'b0, lsu_pkg::L_HU_FN3, 32'd35, '0, 1'b0);
        add_access(1'b0, lsu_pkg::LS_W_FN3, 32'd34, '0, 1'b0);
        add_access(1'b0, lsu_pkg::LS_W_FN3, 32'd33, '0, 1'b0);
        add_access(1'b1, lsu_pkg::LS_H_FN3, 32'd37, rand_bits(32), 1'b0);
        add_access(1'b1, lsu_pkg::LS_W_FN3, 32'd42, rand_bits(32), 1'b0);
        add_access(1'b0, lsu_pkg::LS_W_FN3, 32'd36, '0, 1'b0);
        add_access(1'b0, lsu_pkg::LS_W_FN3, 32'd40, '0, 1'b0);
        // Burst from a drained pipe, then a lone load
        for (int k = 0; k < INPUT_DEPTH + 2; k++) begin
            add_access(1'b0, lsu_pkg::LS_W_FN3, 32'(k * 4), '0, (k == 0));
        end
        add_access(1'b0, lsu_pkg::LS_B_FN3, 32'd35, '0, 1'b1);
    endtask

    //////////////////////////////////////////////////////////////////
    // Compare tasks
    function automatic string format_result(input lsu_pkg::ls_result_t r);
        return $sformatf("id %0d data %08h load %0b mis %0b",
                         r.id, r.data, r.is_load, r.misaligned);
    endfunction

    task automatic check_result(input lsu_pkg::ls_result_t got,
                                input lsu_pkg::ls_result_t exp, input int idx);
        if (got !== exp) begin
            $display("[FAIL] %0t entry %0d: got %s, expected %s",
                     $time, idx, format_result(got), format_result(exp));
            err_count++;
        end else begin
            $display("[PASS] entry %0d id %0d data %08h mis %0b",
                     idx, got.id, got.data, got.misaligned);
            pass_count++;
        end
    endtask

    task automatic check_credit_count(input int got, input int exp, input int idx);
        if (got != exp) begin
            $display("[FAIL] %0t before entry %0d: %0d credits held, expected %0d",
                     $time, idx, got, exp);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_latency(input int got, input int exp, input int idx);
        if (got != exp) begin
            $display("[FAIL] %0t entry %0d: result after %0d cycles, expected %0d",
                     $time, idx, got, exp);
            err_count++;
        end else begin
            pass_count++;
        end
    endtask

    //////////////////////////////////////////////////////////////////
    // Monitor samples on the rising edge where outputs are stable
    always @(posedge clk) begin
        lsu_pkg::ls_result_t exp;
        if (!rst) begin
            if (req_valid) begin
                sent_cycle.push_back(cycle_count);
            end
            if (credit_return) begin
                returned_count++;
            end
            if (result_valid && results_seen >= stim.size()) begin
                $display("Extra result with id %0d after all requests completed", result.id);
                err_count++;
            end else if (result_valid) begin
                exp.id         = 3'(results_seen);
                exp.data       = stim[results_seen].exp_data;
                exp.is_load    = ~stim[results_seen].store;
                exp.misaligned = stim[results_seen].exp_mis;
                check_result(result, exp, results_seen);
                if (stim[results_seen].sync) begin
                    check_latency(cycle_count - sent_cycle[results_seen], LOAD_LATENCY,
                                  results_seen);
                end
                results_seen++;
            end
        end
        cycle_count++;
    end

    initial begin
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(negedge clk);
        end
        $display("Run timed out waiting for results");
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////////////////////
    // Driver
    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        timeout_limit = stim.size() * (INPUT_DEPTH + 8) + 100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < stim.size(); i++) begin
            if (stim[i].sync) begin
                while (results_seen != i) begin
                    @(negedge clk);
                end
                check_credit_count(INPUT_DEPTH - (sent_count - returned_count), INPUT_DEPTH, i);
            end
            // Hold off while every credit is spent
            while (sent_count - returned_count >= INPUT_DEPTH) begin
                @(negedge clk);
            end
            req_valid = 1'b1;
            req.id    = 3'(i);
            req.load  = ~stim[i].store;
            req.store = stim[i].store;
            req.fn3   = stim[i].fn3;
            req.addr  = stim[i].addr;
            req.wdata = stim[i].wdata;
            sent_count++;
            @(negedge clk);
            req_valid = 1'b0;
        end
        while (results_seen != stim.size()) begin
            @(negedge clk);
        end
        // Room for any stray result to show up
        repeat (5) @(negedge clk);
        check_credit_count(INPUT_DEPTH - (sent_count - returned_count), INPUT_DEPTH,
                           stim.size());
        $display("Checks passed %0d, failed %0d", pass_count, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/lsu_pkg.sv
verilog/ls_request_decode.sv
verilog/ls_scratch_memory.sv
verilog/ls_load_result.sv
verilog/load_store_unit.sv
test/lsu_assertions.sv
test/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run of the load/store unit testbench
TOP := lsu_tb

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "Finished with errors" sim.log
	@grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
